/* Bender.yml */
package:
  name: issue

sources:
  - issue_pkg.sv
  - fetch_unit.sv
  - inst_queue.sv
  - predecode.sv
  - dual_issue.sv
  - issue_top.sv
  - target: test
    files:
      - issue_assertions.sv
      - issue_tb.sv

/* build.f */
issue_pkg.sv
fetch_unit.sv
inst_queue.sv
predecode.sv
dual_issue.sv
issue_top.sv
issue_assertions.sv
issue_tb.sv

/* dual_issue.sv */
`timescale 1ns/100ps

module dual_issue (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic [31:0] head_pc_0,
    input  logic [31:0] head_inst_0,
    input  logic        head_ok_0,
    input  logic [31:0] head_pc_1,
    input  logic [31:0] head_inst_1,
    input  logic        head_ok_1,
    output logic        pop_0,
    output logic        pop_1,

    output logic        slot_valid_0,
    output logic [31:0] slot_pc_0,
    output logic [31:0] slot_inst_0,
    output logic [5:0]  op_code_0, funct_0,
    output logic [4:0]  rs_0, rt_0, rd_0, sa_0,
    output logic [15:0] imme_0,
    output logic [25:0] j_imme_0,
    output logic        w_reg_ena_0,
    output logic [4:0]  w_reg_dst_0,
    output logic        is_branch_0, is_j_imme_0, is_jr_0, is_ls_0, is_hilo_0,

    output logic        slot_valid_1,
    output logic [31:0] slot_pc_1,
    output logic [31:0] slot_inst_1,
    output logic [5:0]  op_code_1, funct_1,
    output logic [4:0]  rs_1, rt_1, rd_1, sa_1,
    output logic [15:0] imme_1,
    output logic [25:0] j_imme_1,
    output logic        w_reg_ena_1,
    output logic [4:0]  w_reg_dst_1,
    output logic        is_branch_1, is_j_imme_1, is_jr_1, is_ls_1, is_hilo_1,

    output logic [31:0] dual_count,
    output logic [31:0] single_count
);

    logic jmp_0;
    logic jmp_1;
    logic raw_hazard;

    predecode u_predecode_0 (
        .inst      (head_inst_0),
        .op_code   (op_code_0),
        .funct     (funct_0),
        .rs        (rs_0),
        .rt        (rt_0),
        .rd        (rd_0),
        .sa        (sa_0),
        .imme      (imme_0),
        .j_imme    (j_imme_0),
        .w_reg_ena (w_reg_ena_0),
        .w_reg_dst (w_reg_dst_0),
        .is_branch (is_branch_0),
        .is_j_imme (is_j_imme_0),
        .is_jr     (is_jr_0),
        .is_ls     (is_ls_0),
        .is_hilo   (is_hilo_0)
    );

    predecode u_predecode_1 (
        .inst      (head_inst_1),
        .op_code   (op_code_1),
        .funct     (funct_1),
        .rs        (rs_1),
        .rt        (rt_1),
        .rd        (rd_1),
        .sa        (sa_1),
        .imme      (imme_1),
        .j_imme    (j_imme_1),
        .w_reg_ena (w_reg_ena_1),
        .w_reg_dst (w_reg_dst_1),
        .is_branch (is_branch_1),
        .is_j_imme (is_j_imme_1),
        .is_jr     (is_jr_1),
        .is_ls     (is_ls_1),
        .is_hilo   (is_hilo_1)
    );

    assign jmp_0 = is_branch_0 | is_j_imme_0 | is_jr_0;
    assign jmp_1 = is_branch_1 | is_j_imme_1 | is_jr_1;

    // The younger entry reads a register the older one is about to write.
    assign raw_hazard = w_reg_ena_0 &&
                        (((w_reg_dst_0 == rs_1) && (rs_1 != 5'd0)) ||
                         ((w_reg_dst_0 == rt_1) && (rt_1 != 5'd0)));

    // A jump first overrides every single-issue case, so it is tested first.
    always_comb begin
        pop_0 = 1'b0;
        pop_1 = 1'b0;
        if (!stall && head_ok_0) begin
            pop_0 = 1'b1;
            if (jmp_0) begin
                pop_1 = head_ok_1; // Delay slot goes with its jump.
            end else if (head_ok_1 && raw_hazard) begin
                pop_1 = 1'b0;
            end else if (is_ls_0 || jmp_1 || is_hilo_0) begin
                pop_1 = 1'b0;
            end else begin
                pop_1 = head_ok_1;
            end
        end
    end

    assign slot_valid_0 = pop_0;
    assign slot_pc_0    = head_pc_0;
    assign slot_inst_0  = head_inst_0;
    assign slot_valid_1 = pop_1;
    assign slot_pc_1    = head_pc_1;
    assign slot_inst_1  = head_inst_1;

    always_ff @(posedge clk) begin
        if (rst) begin
            dual_count   <= 32'd0;
            single_count <= 32'd0;
        end else begin
            if (pop_1) begin
                dual_count <= dual_count + 32'd1;
            end else if (pop_0) begin
                single_count <= single_count + 32'd1;
            end
        end
    end

endmodule

/* fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [31:0] in_inst,
    input  logic        full,
    output logic        wr_en,
    output logic [31:0] wr_pc,
    output logic [31:0] wr_inst,
    output logic        overflow
);
    import issue_pkg::*;

    logic [31:0] next_pc;
    logic        drop;

    // A strobe that meets a full queue is lost.
    assign drop = in_valid & full;

    // Every strobe consumes a PC, so a lost word leaves a hole in the sequence.
    always_ff @(posedge clk) begin
        if (rst) begin
            next_pc <= reset_pc;
        end else if (in_valid) begin
            next_pc <= next_pc + 32'd4;
        end
    end

    // Sticky until the next reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            overflow <= 1'b0;
        end else if (drop) begin
            overflow <= 1'b1;
        end
    end

    assign wr_en   = in_valid & ~full;
    assign wr_pc   = next_pc; // The word written at this edge takes the current PC.
    assign wr_inst = in_inst;

endmodule

/* inst_queue.sv */
`timescale 1ns/100ps

module inst_queue (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  logic [31:0] wr_pc,
    input  logic [31:0] wr_inst,
    output logic        full,
    output logic [31:0] head_pc_0,
    output logic [31:0] head_inst_0,
    output logic        head_ok_0,
    output logic [31:0] head_pc_1,
    output logic [31:0] head_inst_1,
    output logic        head_ok_1,
    input  logic        pop_0,
    input  logic        pop_1
);
    import issue_pkg::*;

    logic [31:0] pc_mem   [queue_depth];
    logic [31:0] inst_mem [queue_depth];

    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w-1:0] rd_ptr_nx;
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w:0]   count;
    logic                   wr_accept;
    logic [1:0]             pop_num;

    assign full      = (count == (queue_ptr_w + 1)'(queue_depth));
    assign wr_accept = wr_en & ~full;

    // Pops are only honoured for entries that really exist.
    always_comb begin
        pop_num = 2'd0;
        if (pop_0 && head_ok_0) begin
            pop_num = (pop_1 && head_ok_1) ? 2'd2 : 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            pc_mem[wr_ptr]   <= wr_pc;
            inst_mem[wr_ptr] <= wr_inst;
        end
    end

    // The depth is a power of two, so the pointers wrap on their own.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + queue_ptr_w'(wr_accept);
            rd_ptr <= rd_ptr + queue_ptr_w'(pop_num);
            count  <= count + (queue_ptr_w + 1)'(wr_accept) - (queue_ptr_w + 1)'(pop_num);
        end
    end

    assign rd_ptr_nx = rd_ptr + queue_ptr_w'(1);

    // Two oldest entries, presented combinationally.
    assign head_pc_0   = pc_mem[rd_ptr];
    assign head_inst_0 = inst_mem[rd_ptr];
    assign head_ok_0   = (count != '0);

    assign head_pc_1   = pc_mem[rd_ptr_nx];
    assign head_inst_1 = inst_mem[rd_ptr_nx];
    assign head_ok_1   = (count > (queue_ptr_w + 1)'(1));

endmodule

/* issue_assertions.sv */
`timescale 1ns/100ps

module issue_assertions (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic head_ok_0,
    input logic head_ok_1,
    input logic pop_0,
    input logic pop_1,
    input logic slot_valid_0,
    input logic slot_valid_1,
    input logic is_branch_0,
    input logic is_j_imme_0,
    input logic is_jr_0
);

    int fail_count = 0; // Read by the testbench at the end of the run.

    pop_order: assert property (@(posedge clk) disable iff (rst) pop_1 |-> pop_0)
        else begin
            $error("pop_1 raised without pop_0");
            fail_count++;
        end

    stall_blocks: assert property (@(posedge clk) disable iff (rst)
        stall |-> !slot_valid_0 && !slot_valid_1)
        else begin
            $error("slot issued while stalled");
            fail_count++;
        end

    // A slot may only carry an entry that is really in the queue.
    head_present: assert property (@(posedge clk) disable iff (rst) slot_valid_0 |-> head_ok_0)
        else begin
            $error("slot 0 valid with an empty queue head");
            fail_count++;
        end

    delay_slot: assert property (@(posedge clk) disable iff (rst)
        (slot_valid_0 && (is_branch_0 || is_j_imme_0 || is_jr_0) && head_ok_1) |-> slot_valid_1)
        else begin
            $error("control transfer issued without its delay slot");
            fail_count++;
        end

endmodule

/* issue_pkg.sv */
package issue_pkg;

    // Instruction queue geometry.
    localparam int unsigned queue_depth = 8;
    localparam int unsigned queue_ptr_w = 3;

    localparam logic [31:0] reset_pc = 32'hbfc0_0000; // Boot vector of the core.

    // Primary opcodes of the supported subset.
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // Function codes used under op_special.
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_mfhi    = 6'h10;
    localparam logic [5:0] fn_mflo    = 6'h12;
    localparam logic [5:0] fn_mult    = 6'h18;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_slt     = 6'h2a;

    // One instruction word seen either as register format or as immediate format.
    // The jump target is the low 26 bits of the immediate view.
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] sa;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } inst_word_t;

endpackage

/* issue_tb.sv */
`timescale 1ns/100ps

module issue_tb;
    import issue_pkg::*;

    localparam int directed_strobes = 44;
    localparam int random_strobes   = 200;
    localparam int watchdog_cycles  = (directed_strobes + random_strobes) * 4 + 200;
    localparam int drain_limit      = 64;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        in_valid = 1'b0;
    logic [31:0] in_inst = 32'h0;
    logic        stall = 1'b0;

    logic        slot_valid_0, slot_valid_1;
    logic [31:0] slot_pc_0, slot_inst_0, slot_pc_1, slot_inst_1;
    logic [5:0]  op_code_0, funct_0, op_code_1, funct_1;
    logic [4:0]  rs_0, rt_0, rd_0, sa_0, w_reg_dst_0, rs_1, rt_1, rd_1, sa_1, w_reg_dst_1;
    logic [15:0] imme_0, imme_1;
    logic [25:0] j_imme_0, j_imme_1;
    logic        w_reg_ena_0, is_branch_0, is_j_imme_0, is_jr_0, is_ls_0, is_hilo_0;
    logic        w_reg_ena_1, is_branch_1, is_j_imme_1, is_jr_1, is_ls_1, is_hilo_1;
    logic [31:0] dual_count, single_count;
    logic        overflow;

    // Words believed to sit in the DUT queue, oldest first.
    logic [31:0] mq_pc[$];
    logic [31:0] mq_inst[$];
    logic [31:0] exp_pc = reset_pc;
    logic [31:0] exp_dual = 32'd0;
    logic [31:0] exp_single = 32'd0;
    logic        exp_overflow = 1'b0;
    logic [31:0] base_dual, base_single;
    int          exp_n, held;
    int          err_count = 0, check_count = 0, test_count = 0, start_errs = 0;
    string       test_name = "reset";

    issue_top u_issue_top (.*);

    bind dual_issue issue_assertions u_issue_assertions (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] rtype_word(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                               logic [4:0] rd);
        inst_word_t w;
        w.r = '{op: op_special, rs: rs, rt: rt, rd: rd, sa: 5'd0, funct: fn};
        return w;
    endfunction

    function automatic logic [31:0] itype_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                               logic [15:0] imm);
        inst_word_t w;
        w.i = '{op: op, rs: rs, rt: rt, imm: imm};
        return w;
    endfunction

    function automatic logic [31:0] jump_word(logic [5:0] op, logic [25:0] target);
        return {op, target};
    endfunction

    function automatic logic transfers_control(inst_word_t w);
        return (w.i.op inside {op_beq, op_bne, op_j, op_jal}) ||
               (w.r.op == op_special && w.r.funct == fn_jr);
    endfunction

    function automatic logic accesses_memory(inst_word_t w);
        return w.i.op inside {op_lw, op_sw};
    endfunction

    function automatic logic uses_hilo(inst_word_t w);
        return w.r.op == op_special && (w.r.funct inside {fn_mult, fn_mfhi, fn_mflo});
    endfunction

    // Register written by an instruction; zero stands for no write at all.
    function automatic logic [4:0] written_reg(inst_word_t w);
        if (w.r.op == op_special) begin
            return (w.r.funct inside {fn_addu, fn_subu, fn_and, fn_or, fn_slt, fn_mfhi, fn_mflo})
                   ? w.r.rd : 5'd0;
        end
        if (w.i.op inside {op_addiu, op_ori, op_lui, op_lw}) return w.i.rt;
        return (w.i.op == op_jal) ? 5'd31 : 5'd0;
    endfunction

    // Number of head entries that the pairing rules let issue this cycle.
    function automatic int expected_issue(inst_word_t first, inst_word_t second, int avail,
                                          logic stl);
        logic [4:0] dst;
        logic [4:0] rs_b;
        logic [4:0] rt_b;
        dst  = written_reg(first);
        rs_b = second.i.rs;
        rt_b = second.i.rt;
        if (stl || avail == 0) return 0;
        if (transfers_control(first)) return (avail > 1) ? 2 : 1;
        if (avail == 1) return 1;
        if (dst != 5'd0 && (dst == rs_b || dst == rt_b)) return 1;
        if (accesses_memory(first) || transfers_control(second) || uses_hilo(first)) return 1;
        return 2;
    endfunction

    function automatic logic [31:0] random_word();
        logic [4:0]  a, b, c;
        logic [15:0] imm;
        logic [31:0] w;
        a   = 5'($urandom_range(0, 7)); // Few registers, so hazards are common.
        b   = 5'($urandom_range(0, 7));
        c   = 5'($urandom_range(0, 7));
        imm = 16'($urandom);
        case ($urandom_range(0, 17))
            0:  w = rtype_word(fn_addu, a, b, c);
            1:  w = rtype_word(fn_subu, a, b, c);
            2:  w = rtype_word(fn_and, a, b, c);
            3:  w = rtype_word(fn_or, a, b, c);
            4:  w = rtype_word(fn_slt, a, b, c);
            5:  w = rtype_word(fn_jr, a, 5'd0, 5'd0);
            6:  w = rtype_word(fn_mult, a, b, 5'd0);
            7:  w = rtype_word(fn_mfhi, 5'd0, 5'd0, c);
            8:  w = rtype_word(fn_mflo, 5'd0, 5'd0, c);
            9:  w = jump_word(op_j, 26'($urandom));
            10: w = jump_word(op_jal, 26'($urandom));
            11: w = itype_word(op_beq, a, b, imm);
            12: w = itype_word(op_bne, a, b, imm);
            13: w = itype_word(op_addiu, a, b, imm);
            14: w = itype_word(op_ori, a, b, imm);
            15: w = itype_word(op_lui, 5'd0, b, imm);
            16: w = itype_word(op_lw, a, b, imm);
            default: w = itype_word(op_sw, a, b, imm);
        endcase
        return w;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        assert (exp === act) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp, act);
            err_count++;
        end
    endtask

    // Decoded fields and class flags of one issued slot, taken from the word itself.
    task automatic compare_fields(input string slot, input inst_word_t w,
                                  input logic [5:0] op_code, input logic [5:0] funct,
                                  input logic [4:0] rs, input logic [4:0] rt,
                                  input logic [4:0] rd, input logic [4:0] sa,
                                  input logic [15:0] imme, input logic [25:0] j_imme,
                                  input logic w_ena, input logic [4:0] w_dst,
                                  input logic [4:0] flags);
        logic [31:0] raw;
        logic [4:0]  dst;
        logic [4:0]  exp_flags;
        raw       = w;
        dst       = written_reg(w);
        exp_flags = {(w.i.op inside {op_beq, op_bne}), (w.i.op inside {op_j, op_jal}),
                     (w.r.op == op_special && w.r.funct == fn_jr),
                     accesses_memory(w), uses_hilo(w)};
        check_value({slot, " op_code"}, 32'(raw[31:26]), 32'(op_code));
        check_value({slot, " rs"}, 32'(raw[25:21]), 32'(rs));
        check_value({slot, " rt"}, 32'(raw[20:16]), 32'(rt));
        if (w.r.op == op_special) begin
            check_value({slot, " rd"}, 32'(w.r.rd), 32'(rd));
            check_value({slot, " sa"}, 32'(w.r.sa), 32'(sa));
            check_value({slot, " funct"}, 32'(w.r.funct), 32'(funct));
        end else begin
            check_value({slot, " imme"}, 32'(w.i.imm), 32'(imme));
        end
        if (exp_flags[3]) begin
            check_value({slot, " j_imme"}, 32'(raw[25:0]), 32'(j_imme));
        end
        check_value({slot, " w_reg_ena"}, 32'(dst != 5'd0), 32'(w_ena));
        if (dst != 5'd0) begin
            check_value({slot, " w_reg_dst"}, 32'(dst), 32'(w_dst));
        end
        check_value({slot, " flags"}, 32'(exp_flags), 32'(flags));
    endtask

    // Entered and left on a falling edge, one strobe per call.
    task automatic send_word(input logic [31:0] w);
        in_valid = 1'b1;
        in_inst  = w;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (mq_inst.size() != 0 && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (mq_inst.size() != 0) begin
            $display("Queue did not drain within %0d cycles in test %s.", drain_limit, test_name);
            err_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        start_errs  = err_count;
        base_dual   = dual_count;
        base_single = single_count;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %-12s done, %0d errors", test_name, err_count - start_errs);
    endtask

    // Outputs are compared with the model before this edge takes effect.
    always @(posedge clk) begin
        if (!rst) begin
            held  = mq_inst.size();
            exp_n = expected_issue(held > 0 ? mq_inst[0] : 32'h0,
                                   held > 1 ? mq_inst[1] : 32'h0, held, stall);
            check_value("slot_valid_0", 32'(exp_n >= 1), 32'(slot_valid_0));
            check_value("slot_valid_1", 32'(exp_n == 2), 32'(slot_valid_1));
            if (exp_n >= 1) begin
                check_value("slot_pc_0", mq_pc[0], slot_pc_0);
                check_value("slot_inst_0", mq_inst[0], slot_inst_0);
                compare_fields("slot_0", mq_inst[0], op_code_0, funct_0, rs_0, rt_0, rd_0, sa_0,
                               imme_0, j_imme_0, w_reg_ena_0, w_reg_dst_0,
                               {is_branch_0, is_j_imme_0, is_jr_0, is_ls_0, is_hilo_0});
            end
            if (exp_n == 2) begin
                check_value("slot_pc_1", mq_pc[1], slot_pc_1);
                check_value("slot_inst_1", mq_inst[1], slot_inst_1);
                compare_fields("slot_1", mq_inst[1], op_code_1, funct_1, rs_1, rt_1, rd_1, sa_1,
                               imme_1, j_imme_1, w_reg_ena_1, w_reg_dst_1,
                               {is_branch_1, is_j_imme_1, is_jr_1, is_ls_1, is_hilo_1});
            end
            check_value("dual_count", exp_dual, dual_count);
            check_value("single_count", exp_single, single_count);
            check_value("overflow", 32'(exp_overflow), 32'(overflow));
            if (exp_n == 2) exp_dual++;
            else if (exp_n == 1) exp_single++;
            if (in_valid) begin
                if (held == queue_depth) begin
                    exp_overflow = 1'b1; // Full before this edge, so the word is lost.
                end else begin
                    mq_pc.push_back(exp_pc);
                    mq_inst.push_back(in_inst);
                end
                exp_pc += 32'd4;
            end
            repeat (exp_n) begin
                void'(mq_pc.pop_front());
                void'(mq_inst.pop_front());
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Run stopped by timeout after %0d cycles in test %s.", watchdog_cycles, test_name);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h1ca38720));
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("alu_pairs");
        stall = 1'b1;
        send_word(rtype_word(fn_addu, 5'd10, 5'd11, 5'd1));
        send_word(rtype_word(fn_subu, 5'd12, 5'd13, 5'd2));
        send_word(rtype_word(fn_and, 5'd14, 5'd15, 5'd3));
        send_word(rtype_word(fn_or, 5'd16, 5'd17, 5'd4));
        send_word(rtype_word(fn_slt, 5'd18, 5'd19, 5'd5));
        send_word(itype_word(op_ori, 5'd20, 5'd6, 16'h00ff));
        send_word(itype_word(op_addiu, 5'd21, 5'd7, 16'h0010));
        send_word(itype_word(op_lui, 5'd0, 5'd8, 16'h1234));
        stall = 1'b0;
        wait_drain();
        check_value("pairs", base_dual + 32'd4, dual_count);
        end_test();

        start_test("single_issue");
        stall = 1'b1;
        send_word(rtype_word(fn_addu, 5'd2, 5'd3, 5'd1));
        send_word(rtype_word(fn_addu, 5'd1, 5'd5, 5'd4));   // Reads r1 just written.
        send_word(itype_word(op_lw, 5'd4, 5'd6, 16'h0000));
        send_word(rtype_word(fn_addu, 5'd9, 5'd10, 5'd8));  // Behind a load.
        send_word(rtype_word(fn_mult, 5'd8, 5'd11, 5'd0));
        send_word(rtype_word(fn_addu, 5'd16, 5'd17, 5'd12));
        send_word(itype_word(op_beq, 5'd13, 5'd14, 16'h0004));
        send_word(rtype_word(fn_addu, 5'd19, 5'd20, 5'd18));
        stall = 1'b0;
        wait_drain();
        stall = 1'b1;
        send_word(rtype_word(fn_addu, 5'd2, 5'd3, 5'd0));
        send_word(rtype_word(fn_addu, 5'd0, 5'd0, 5'd21));
        stall = 1'b0;
        wait_drain();
        check_value("singles", base_single + 32'd6, single_count);
        check_value("pairs", base_dual + 32'd2, dual_count);
        end_test();

        start_test("delay_slot");
        stall = 1'b1;
        send_word(jump_word(op_jal, 26'h0000100));
        send_word(rtype_word(fn_addu, 5'd31, 5'd0, 5'd5));  // Uses the link register.
        send_word(jump_word(op_j, 26'h0000200));
        send_word(itype_word(op_lw, 5'd7, 5'd6, 16'h0004));
        send_word(rtype_word(fn_jr, 5'd31, 5'd0, 5'd0));
        send_word(itype_word(op_bne, 5'd1, 5'd2, 16'h0008));
        send_word(itype_word(op_addiu, 5'd2, 5'd2, 16'h0001));
        send_word(itype_word(op_beq, 5'd3, 5'd4, 16'hfff0));
        stall = 1'b0;
        wait_drain();
        check_value("pairs", base_dual + 32'd3, dual_count);
        check_value("singles", base_single + 32'd2, single_count);
        end_test();

        start_test("stall_drain");
        stall = 1'b1;
        repeat (6) send_word(random_word());
        repeat (5) @(negedge clk);
        stall = 1'b0;
        wait_drain();
        end_test();

        start_test("overflow");
        stall = 1'b1;
        for (int i = 0; i < queue_depth + 4; i++) begin
            send_word(rtype_word(fn_addu, 5'(i), 5'(i + 1), 5'(i + 16)));
        end
        check_value("overflow_set", 32'd1, 32'(overflow));
        stall = 1'b0;
        wait_drain();
        end_test();

        start_test("random_mix");
        for (int i = 0; i < random_strobes; i++) begin
            stall = ($urandom_range(0, 3) == 0);
            send_word(random_word());
            repeat ($urandom_range(0, 3)) begin
                stall = ($urandom_range(0, 3) == 0);
                @(negedge clk);
            end
        end
        stall = 1'b0;
        wait_drain();
        check_value("final_dual", exp_dual, dual_count);
        check_value("final_single", exp_single, single_count);
        end_test();

        err_count += u_issue_top.u_dual_issue.u_issue_assertions.fail_count;
        $display("%0d tests, %0d checks, %0d errors, dual %0d, single %0d",
                 test_count, check_count, err_count, dual_count, single_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* issue_top.sv */
`timescale 1ns/100ps

module issue_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [31:0] in_inst,
    input  logic        stall,

    output logic        slot_valid_0,
    output logic [31:0] slot_pc_0,
    output logic [31:0] slot_inst_0,
    output logic [5:0]  op_code_0, funct_0,
    output logic [4:0]  rs_0, rt_0, rd_0, sa_0,
    output logic [15:0] imme_0,
    output logic [25:0] j_imme_0,
    output logic        w_reg_ena_0,
    output logic [4:0]  w_reg_dst_0,
    output logic        is_branch_0, is_j_imme_0, is_jr_0, is_ls_0, is_hilo_0,

    output logic        slot_valid_1,
    output logic [31:0] slot_pc_1,
    output logic [31:0] slot_inst_1,
    output logic [5:0]  op_code_1, funct_1,
    output logic [4:0]  rs_1, rt_1, rd_1, sa_1,
    output logic [15:0] imme_1,
    output logic [25:0] j_imme_1,
    output logic        w_reg_ena_1,
    output logic [4:0]  w_reg_dst_1,
    output logic        is_branch_1, is_j_imme_1, is_jr_1, is_ls_1, is_hilo_1,

    output logic [31:0] dual_count,
    output logic [31:0] single_count,
    output logic        overflow
);

    // Fetch to queue.
    logic        wr_en;
    logic [31:0] wr_pc;
    logic [31:0] wr_inst;
    logic        full;

    // Queue head and pop handshake.
    logic [31:0] head_pc_0, head_inst_0;
    logic [31:0] head_pc_1, head_inst_1;
    logic        head_ok_0, head_ok_1;
    logic        pop_0, pop_1;

    // Fetch fills the queue and the issue logic drains it.
    fetch_unit u_fetch_unit (.*);

    inst_queue u_inst_queue (.*);

    dual_issue u_dual_issue (.*);

endmodule

/* predecode.sv */
`timescale 1ns/100ps

module predecode (
    input  issue_pkg::inst_word_t inst,
    output logic [5:0]            op_code,
    output logic [5:0]            funct,
    output logic [4:0]            rs,
    output logic [4:0]            rt,
    output logic [4:0]            rd,
    output logic [4:0]            sa,
    output logic [15:0]           imme,
    output logic [25:0]           j_imme,
    output logic                  w_reg_ena,
    output logic [4:0]            w_reg_dst,
    output logic                  is_branch,
    output logic                  is_j_imme,
    output logic                  is_jr,
    output logic                  is_ls,
    output logic                  is_hilo
);
    import issue_pkg::*;

    logic is_special;
    logic writes;

    assign is_special = (inst.r.op == op_special);

    assign is_branch = (inst.i.op == op_beq) || (inst.i.op == op_bne);
    assign is_j_imme = (inst.i.op == op_j) || (inst.i.op == op_jal);
    assign is_jr     = is_special && (inst.r.funct == fn_jr);
    assign is_ls     = (inst.i.op == op_lw) || (inst.i.op == op_sw);
    assign is_hilo   = is_special && ((inst.r.funct == fn_mult) ||
                                      (inst.r.funct == fn_mfhi) ||
                                      (inst.r.funct == fn_mflo));

    // Field extraction follows the format the opcode implies.
    always_comb begin
        op_code = inst.r.op;
        rs      = inst.i.rs;
        rt      = inst.i.rt;
        rd      = '0;
        sa      = '0;
        funct   = '0;
        imme    = '0;
        j_imme  = '0;
        if (is_special) begin
            rd    = inst.r.rd;
            sa    = inst.r.sa;
            funct = inst.r.funct;
        end else begin
            imme = inst.i.imm;
        end
        if (is_j_imme) begin
            j_imme = {inst.i.rs, inst.i.rt, inst.i.imm};
        end
    end

    always_comb begin
        writes    = 1'b0;
        w_reg_dst = '0;
        case (inst.r.op)
            op_special: begin
                case (inst.r.funct)
                    fn_addu, fn_subu, fn_and, fn_or, fn_slt, fn_mfhi, fn_mflo: begin
                        writes    = 1'b1;
                        w_reg_dst = inst.r.rd;
                    end
                    default: ;
                endcase
            end
            op_addiu, op_ori, op_lui, op_lw: begin
                writes    = 1'b1;
                w_reg_dst = inst.i.rt;
            end
            op_jal: begin
                writes    = 1'b1;
                w_reg_dst = 5'd31; // Link register.
            end
            default: ;
        endcase
    end

    assign w_reg_ena = writes && (w_reg_dst != 5'd0); // $zero is never a real destination.

endmodule
